/* Makefile */
TOP = mem_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* hdl/ag_me_latch.sv */
`timescale 1ns/10ps

module ag_me_latch (
   input  logic                  clk,
   input  logic                  rst_n,
   input  mem_stage_pkg::ag_me_t in,
   input  logic                  in_valid,
   input  logic                  take,
   output logic                  in_ready,
   output mem_stage_pkg::ag_me_t lat_entry,
   output logic                  lat_valid
);

   logic ld_me;

   // the slot frees up in the same cycle the control block takes it
   assign in_ready = !lat_valid || take;
   assign ld_me = in_valid && in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lat_valid <= 1'b0;
      end else if (ld_me) begin
         lat_valid <= 1'b1;   // a reload wins over the clear
      end else if (take) begin
         lat_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_me) begin
         lat_entry <= in;
      end
   end

endmodule

/* hdl/dcache_array.sv */
`timescale 1ns/10ps
`include "mem_stage_defines.svh"

module dcache_array (
   input  logic                                clk,
   input  logic                                en,
   input  logic                                we,
   input  logic [$clog2(`ME_DCACHE_DEPTH)-1:0] index,
   input  logic [7:0]                          byte_mask,
   input  logic [63:0]                         wdata,
   output logic [63:0]                         rdata
);

   logic [63:0] mem [`ME_DCACHE_DEPTH];

   // the cache starts out cleared
   initial begin
      for (int i = 0; i < `ME_DCACHE_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int b = 0; b < 8; b++) begin
            if (byte_mask[b]) begin
               mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end
      end
   end

   // read data lands one cycle after the enable and holds until the next read
   always_ff @(posedge clk) begin
      if (en && !we) begin
         rdata <= mem[index];
      end
   end

endmodule

/* hdl/dcache_latency_timer.sv */
`timescale 1ns/10ps
`include "mem_stage_defines.svh"

module dcache_latency_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   output logic done,
   output logic busy
);

   localparam int CNT_W = $clog2(`ME_DCACHE_LAT + 1);

   logic [CNT_W-1:0] count;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (start) begin
         count <= CNT_W'(`ME_DCACHE_LAT);
      end else if (busy) begin
         count <= count - 1'b1;
      end
   end

   assign busy = (count != '0);
   assign done = (count == CNT_W'(1));   // last cycle of the access

endmodule

/* hdl/me_ctrl_fsm.sv */
`timescale 1ns/10ps

module me_ctrl_fsm (
   input  logic                      clk,
   input  logic                      rst_n,
   input  mem_stage_pkg::ag_me_t     lat_entry,
   input  logic                      lat_valid,
   output logic                      take,
   output logic                      timer_start,
   input  logic                      timer_done,
   output logic                      cache_en,
   output logic                      cache_we,
   input  logic [63:0]               load_val,
   output mem_stage_pkg::data_size_e cur_size,
   output logic [31:0]               cur_addr,
   output logic [63:0]               cur_wdata,
   output mem_stage_pkg::me_wb_t     out,
   output logic                      out_valid,
   input  logic                      out_ready
);

   import mem_stage_pkg::*;

   me_state_e state, state_nxt;
   ag_me_t    cur;

   // an entry is taken from idle, or as the held result leaves
   assign take = lat_valid && ((state == ME_IDLE) || ((state == ME_HOLD) && out_ready));
   assign timer_start = take && (lat_entry.op != MEM_NONE);

   always_comb begin
      state_nxt = state;
      case (state)
         ME_IDLE: begin
            if (take) begin
               state_nxt = (lat_entry.op == MEM_NONE) ? ME_HOLD : ME_ACCESS;
            end
         end
         ME_ACCESS: begin
            if (timer_done) begin
               state_nxt = ME_HOLD;
            end
         end
         ME_HOLD: begin
            if (take) begin
               state_nxt = (lat_entry.op == MEM_NONE) ? ME_HOLD : ME_ACCESS;
            end else if (out_ready) begin
               state_nxt = ME_IDLE;
            end
         end
         default: state_nxt = ME_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ME_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         cur <= lat_entry;
      end
   end

   // the write lands on the last access cycle only, so a store writes once
   assign cache_en = (state == ME_ACCESS);
   assign cache_we = cache_en && timer_done && (cur.op == MEM_STORE);

   assign cur_size  = cur.size;
   assign cur_addr  = cur.addr;
   assign cur_wdata = cur.wdata;

   // the cache is idle in ME_HOLD, so the read line and load_val stay put
   always_comb begin
      out.result = (cur.op == MEM_LOAD) ? load_val : cur.wdata;
      out.drid   = cur.drid;
      out.ld_gpr = cur.ld_gpr;
   end

   assign out_valid = (state == ME_HOLD);

endmodule

/* hdl/mem_align.sv */
`timescale 1ns/10ps

module mem_align (
   input  mem_stage_pkg::data_size_e size,
   input  logic [2:0]                offset,
   input  logic [63:0]               store_data,
   input  logic [63:0]               line,
   output logic [7:0]                byte_mask,
   output logic [63:0]               placed_data,
   output logic [63:0]               load_val
);

   import mem_stage_pkg::*;

   logic [7:0]  size_mask;
   logic [63:0] line_shifted;

   // widens a byte mask to a bit mask over the line
   function automatic logic [63:0] expand_mask(input logic [7:0] m);
      logic [63:0] bits;
      for (int b = 0; b < 8; b++) begin
         bits[b*8 +: 8] = {8{m[b]}};
      end
      return bits;
   endfunction

   always_comb begin
      case (size)
         SZ_BYTE:  size_mask = 8'h01;
         SZ_WORD:  size_mask = 8'h03;
         SZ_DWORD: size_mask = 8'h0f;
         default:  size_mask = 8'hff;
      endcase
   end

   // bytes pushed past byte 7 fall off, nothing crosses into the next line
   assign byte_mask   = 8'(size_mask << offset);
   assign placed_data = store_data << {offset, 3'b000};

   // the right shift fills zeros, which gives the zero bytes above offset 7
   assign line_shifted = line >> {offset, 3'b000};
   assign load_val     = line_shifted & expand_mask(size_mask);

endmodule

/* hdl/mem_stage_pkg.sv */
package mem_stage_pkg;

   // memory operation carried by an entry
   typedef enum logic [1:0] {
      MEM_NONE  = 2'd0,
      MEM_LOAD  = 2'd1,
      MEM_STORE = 2'd2
   } mem_op_e;

   // an access covers 1 << size bytes
   typedef enum logic [1:0] {
      SZ_BYTE  = 2'd0,
      SZ_WORD  = 2'd1,
      SZ_DWORD = 2'd2,
      SZ_QWORD = 2'd3
   } data_size_e;

   typedef enum logic [1:0] {
      ME_IDLE   = 2'd0,
      ME_ACCESS = 2'd1,
      ME_HOLD   = 2'd2
   } me_state_e;

   // one operation coming from address generation
   typedef struct packed {
      mem_op_e     op;
      data_size_e  size;
      logic [31:0] addr;
      logic [63:0] wdata;   // store data, or the ALU result for MEM_NONE
      logic [2:0]  drid;
      logic        ld_gpr;
   } ag_me_t;

   // one result headed for writeback
   typedef struct packed {
      logic [63:0] result;
      logic [2:0]  drid;
      logic        ld_gpr;
   } me_wb_t;

endpackage

/* hdl/mem_stage_top.sv */
`timescale 1ns/10ps
`include "mem_stage_defines.svh"

module mem_stage_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  mem_stage_pkg::ag_me_t in,
   input  logic                  in_valid,
   output logic                  in_ready,
   output mem_stage_pkg::me_wb_t out,
   output logic                  out_valid,
   input  logic                  out_ready
);

   import mem_stage_pkg::*;

   localparam int IDX_W = $clog2(`ME_DCACHE_DEPTH);

   ag_me_t      lat_entry;
   logic        lat_valid;
   logic        take;
   logic        timer_start;
   logic        timer_done;
   logic        cache_en;
   logic        cache_we;
   data_size_e  cur_size;
   logic [31:0] cur_addr;
   logic [63:0] cur_wdata;
   logic [7:0]  byte_mask;
   logic [63:0] placed_data;
   logic [63:0] rdata;
   logic [63:0] load_val;

   ag_me_latch u_latch (
      .clk       (clk),
      .rst_n     (rst_n),
      .in        (in),
      .in_valid  (in_valid),
      .take      (take),
      .in_ready  (in_ready),
      .lat_entry (lat_entry),
      .lat_valid (lat_valid)
   );

   me_ctrl_fsm u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .lat_entry   (lat_entry),
      .lat_valid   (lat_valid),
      .take        (take),
      .timer_start (timer_start),
      .timer_done  (timer_done),
      .cache_en    (cache_en),
      .cache_we    (cache_we),
      .load_val    (load_val),
      .cur_size    (cur_size),
      .cur_addr    (cur_addr),
      .cur_wdata   (cur_wdata),
      .out         (out),
      .out_valid   (out_valid),
      .out_ready   (out_ready)
   );

   dcache_latency_timer u_timer (
      .clk   (clk),
      .rst_n (rst_n),
      .start (timer_start),
      .done  (timer_done),
      .busy  ()
   );

   // line index is the address above the byte offset, modulo the depth
   dcache_array u_dcache (
      .clk       (clk),
      .en        (cache_en),
      .we        (cache_we),
      .index     (cur_addr[IDX_W+2:3]),
      .byte_mask (byte_mask),
      .wdata     (placed_data),
      .rdata     (rdata)
   );

   mem_align u_align (
      .size        (cur_size),
      .offset      (cur_addr[2:0]),
      .store_data  (cur_wdata),
      .line        (rdata),
      .byte_mask   (byte_mask),
      .placed_data (placed_data),
      .load_val    (load_val)
   );

endmodule

/* include/mem_stage_defines.svh */
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// the data cache holds this many 64-bit lines and the count is a power of two
// the line index comes from the address bits above bit 2, so the
// depth also sets how many of those bits take part in the lookup
`define ME_DCACHE_DEPTH 64

// clock cycles that one cache access keeps the memory stage busy
// must be 1 or more
`define ME_DCACHE_LAT 3

`endif

/* project.f */
+incdir+include
hdl/mem_stage_pkg.sv
hdl/ag_me_latch.sv
hdl/me_ctrl_fsm.sv
hdl/dcache_latency_timer.sv
hdl/dcache_array.sv
hdl/mem_align.sv
hdl/mem_stage_top.sv
verif/mem_stage_checker.sv
verif/mem_stage_tb.sv

/* verif/mem_stage_checker.sv */
`timescale 1ns/10ps

module mem_stage_checker (
   input logic                  clk,
   input logic                  rst_n,
   input mem_stage_pkg::ag_me_t in,
   input logic                  in_valid,
   input logic                  in_ready,
   input mem_stage_pkg::me_wb_t out,
   input logic                  out_valid,
   input logic                  out_ready
);

   property out_idle_in_reset;
      @(posedge clk) !rst_n |-> !out_valid;
   endproperty

   // a stalled result must not change before writeback takes it
   property out_stable_when_stalled;
      @(posedge clk) disable iff (!rst_n)
         (out_valid && !out_ready) |=> (out_valid && $stable(out));
   endproperty

   property in_known_on_transfer;
      @(posedge clk) disable iff (!rst_n)
         (in_valid && in_ready) |-> !$isunknown(in);
   endproperty

   a_out_idle_in_reset: assert property (out_idle_in_reset)
      else $error("out_valid is high during reset");

   a_out_stable_when_stalled: assert property (out_stable_when_stalled)
      else $error("out changed or dropped while out_ready was low");

   a_in_known_on_transfer: assert property (in_known_on_transfer)
      else $error("an entry with unknown bits was accepted on the in port");

endmodule

bind mem_stage_top mem_stage_checker u_checker (
   .clk       (clk),
   .rst_n     (rst_n),
   .in        (in),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .out       (out),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

/* verif/mem_stage_tb.sv */
`timescale 1ns/10ps
`include "mem_stage_defines.svh"

module mem_stage_tb;

   import mem_stage_pkg::*;

   localparam int     N_EMPTY     = 32;
   localparam int     N_PAIRS     = 96;
   localparam int     N_PASS      = 8;
   localparam int     N_RANDOM    = 200;
   localparam int     N_OPS       = N_EMPTY + N_PAIRS + N_PASS + N_RANDOM;
   localparam longint WATCHDOG_NS = longint'(N_OPS) * (`ME_DCACHE_LAT + 10) * 100;

   typedef struct packed {
      me_wb_t      wb;
      logic        idle;         // accepted with nothing else in flight
      logic        is_mem;
      logic [31:0] accept_cyc;
   } expect_t;

   logic        clk;
   logic        rst_n;
   ag_me_t      in;
   logic        in_valid;
   logic        in_ready;
   me_wb_t      out;
   logic        out_valid;
   logic        out_ready;

   logic [7:0]  model [`ME_DCACHE_DEPTH*8];
   expect_t     exp_q [$];
   logic [31:0] cycle;
   logic [31:0] n_accepted;
   logic [31:0] n_done;
   logic [31:0] stim_state;
   logic        backpressure;
   logic        saw_stall;

   mem_stage_top UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in        (in),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out       (out),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_stim();
      stim_state = xorshift32(stim_state);
      return stim_state;
   endfunction

   // bits above the index are random, so the cache has to wrap them away
   function automatic logic [31:0] make_addr(input logic [3:0] line, input logic [2:0] offset);
      logic [31:0] a;
      a = next_stim();
      a[8:0] = {2'b00, line, offset};
      return a;
   endfunction

   function automatic ag_me_t make_op(input mem_op_e op, input data_size_e size,
                                      input logic [31:0] addr);
      ag_me_t      e;
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] meta;
      lo       = next_stim();
      hi       = next_stim();
      meta     = next_stim();
      e.op     = op;
      e.size   = size;
      e.addr   = addr;
      e.wdata  = {hi, lo};
      e.drid   = meta[2:0];
      e.ld_gpr = meta[3];
      return e;
   endfunction

   // works out the expected writeback value and updates the byte model on a store
   function automatic me_wb_t ref_result(input ag_me_t e);
      me_wb_t r;
      int     nbytes;
      int     line;
      int     pos;
      nbytes   = 1 << int'(e.size);
      line     = int'((e.addr >> 3) % `ME_DCACHE_DEPTH);
      r.result = (e.op == MEM_LOAD) ? 64'd0 : e.wdata;
      r.drid   = e.drid;
      r.ld_gpr = e.ld_gpr;
      for (int i = 0; i < nbytes; i++) begin
         pos = int'(e.addr[2:0]) + i;
         if (pos < 8) begin   // bytes past the end of the line are dropped
            if (e.op == MEM_LOAD) begin
               r.result[i*8 +: 8] = model[line*8 + pos];
            end else if (e.op == MEM_STORE) begin
               model[line*8 + pos] = e.wdata[i*8 +: 8];
            end
         end
      end
      return r;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected) begin
         stop_on_error($sformatf("FAILED at %0d ns: %s is %h, expected %h",
                                 $time, what, got, expected));
      end
   endtask

   // called just after a falling edge, returns on the falling edge after the transfer
   task automatic send_op(input ag_me_t e);
      in       = e;
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready) begin
         @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_idle();
      while (n_accepted != n_done) begin
         @(negedge clk);
      end
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cycle <= '0;
      end else begin
         cycle <= cycle + 1;
      end
   end

   always @(posedge clk or negedge rst_n) begin : accept_monitor
      expect_t e;
      if (!rst_n) begin
         n_accepted <= '0;
         saw_stall  <= 1'b0;
      end else begin
         if (in_valid && in_ready) begin
            e.wb         = ref_result(in);
            e.idle       = (n_accepted == n_done);
            e.is_mem     = (in.op != MEM_NONE);
            e.accept_cyc = cycle;
            exp_q.push_back(e);
            n_accepted <= n_accepted + 1;
         end
         if (in_valid && !in_ready) begin
            saw_stall <= 1'b1;
         end
      end
   end

   always @(posedge clk or negedge rst_n) begin : compare_results
      expect_t     e;
      logic        head_seen;
      logic [31:0] head_first;
      if (!rst_n) begin
         n_done    <= '0;
         head_seen = 1'b0;
      end else begin
         if (out_valid && !head_seen) begin
            head_seen  = 1'b1;
            head_first = cycle;
         end
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               stop_on_error("a result came out of the DUT with no operation outstanding");
            end else begin
               e = exp_q.pop_front();
               check_value("result", out.result, e.wb.result);
               check_value("drid", 64'(out.drid), 64'(e.wb.drid));
               check_value("ld_gpr", 64'(out.ld_gpr), 64'(e.wb.ld_gpr));
               // out_valid rises after edge N+1, or N+1+LAT for a cache access,
               // so it is first sampled one edge later
               if (e.idle) begin
                  check_value("cycles from acceptance to out_valid",
                              64'(head_first - e.accept_cyc),
                              e.is_mem ? 64'(`ME_DCACHE_LAT + 2) : 64'd2);
               end
               head_seen = 1'b0;
               n_done <= n_done + 1;
            end
         end
      end
   end

   initial begin : drive_out_ready
      logic [31:0] rdy_state;
      rdy_state = 32'd74 ^ 32'h9e37_79b9;
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         rdy_state = xorshift32(rdy_state);
         out_ready = backpressure ? rdy_state[4] : 1'b1;   // stalls about half the time
      end
   end

   initial begin : main_sequence
      ag_me_t      e;
      logic [31:0] r;
      rst_n        = 1'b0;
      in           = '0;
      in_valid     = 1'b0;
      backpressure = 1'b0;
      stim_state   = 32'd74;
      for (int i = 0; i < `ME_DCACHE_DEPTH*8; i++) begin
         model[i] = 8'h00;
      end
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("out_valid after reset", 64'(out_valid), 64'd0);
      check_value("in_ready after reset", 64'(in_ready), 64'd1);

      for (int s = 0; s < 4; s++) begin
         for (int o = 0; o < 8; o++) begin
            send_op(make_op(MEM_LOAD, data_size_e'(s), make_addr(4'(s*8 + o), 3'(o))));
            wait_idle();
         end
      end

      // store, load it back, then read the whole line to see the untouched bytes
      for (int s = 0; s < 4; s++) begin
         for (int o = 0; o < 8; o++) begin
            e = make_op(MEM_STORE, data_size_e'(s), make_addr(4'(s*8 + o), 3'(o)));
            send_op(e);
            wait_idle();
            e.op = MEM_LOAD;
            send_op(e);
            wait_idle();
            e.size      = SZ_QWORD;
            e.addr[2:0] = 3'd0;
            send_op(e);
            wait_idle();
         end
      end

      for (int i = 0; i < N_PASS; i++) begin
         r = next_stim();
         send_op(make_op(MEM_NONE, data_size_e'(r[13:12]), make_addr(r[7:4], r[10:8])));
         wait_idle();
      end

      @(posedge clk);
      backpressure = 1'b1;
      @(negedge clk);
      for (int i = 0; i < N_RANDOM; i++) begin
         r = next_stim();
         if (r[15:14] == 2'b00) begin
            @(negedge clk);
         end
         send_op(make_op(mem_op_e'(2'(r % 3)), data_size_e'(r[13:12]),
                         make_addr(r[7:4], r[10:8])));
      end
      wait_idle();
      @(posedge clk);
      backpressure = 1'b0;
      @(negedge clk);

      // with every result returned the stage has to be empty again
      check_value("out_valid after the last result", 64'(out_valid), 64'd0);
      check_value("in_ready after the last result", 64'(in_ready), 64'd1);

      if (!saw_stall) begin
         stop_on_error("in_ready never fell while the output was stalled");
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      stop_on_error($sformatf("timeout: the run did not finish within %0d ns", WATCHDOG_NS));
   end

endmodule
